// File: include/mp64_defines.svh
/*
 Sizing and constant macros for the shared memory port.
 Changing MP64_NUM_CORES also requires MP64_CORE_ID_BITS to hold a core index.
 The top address bit selects the register region, so RAM space is half the map.
*/
`ifndef MP64_DEFINES_SVH
`define MP64_DEFINES_SVH

// ========================================
// Requesters
// ========================================
// Cores sharing the port
`define MP64_NUM_CORES       4
// Enough bits to name any core
`define MP64_CORE_ID_BITS    2

// ========================================
// Bus widths
// ========================================
`define MP64_DATA_BITS       64
// Word address, MSB picks RAM (0) or registers (1)
`define MP64_ADDR_BITS       11
// RAM index width, 1024 words
`define MP64_RAM_ADDR_BITS   10

// ========================================
// Register unit
// ========================================
// Hardware spinlocks
`define MP64_NUM_LOCKS       8
// "MP64" v2.1 identification word
`define MP64_SYSINFO_ID      64'h4D50_3634_0002_0001
// Offset of lock 0 inside the register region
`define MP64_LOCK_BASE       'h10

`endif

// File: design/mp64_pkg.sv
/*
 Shared types for the multi-core memory port.
 Widths come from mp64_defines.svh, which must be on the include path.
*/
`include "mp64_defines.svh"

package mp64_pkg;

    // Requester index, also the spinlock owner tag
    typedef logic [`MP64_CORE_ID_BITS-1:0] core_id_t;

    // Data word on every port
    typedef logic [`MP64_DATA_BITS-1:0] word_t;

    // Word address, MSB is the region select
    typedef logic [`MP64_ADDR_BITS-1:0] addr_t;

    // Arbiter FSM, one access in flight at most
    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_BUSY = 1'b1
    } arb_state_e;

    // Register unit decode of the low address bits
    typedef enum logic [2:0] {
        REG_ID         = 3'd0,
        REG_RAM_SIZE   = 3'd1,
        REG_CORE_COUNT = 3'd2,
        // Whole lock window at LOCK_BASE
        REG_LOCK       = 3'd3,
        // Unmapped, reads as zero
        REG_NONE       = 3'd4
    } reg_sel_e;

endpackage

// File: design/core_bus_arbiter.sv
/*
 Round-robin arbiter for the cores in front of the RAM and the register unit.
 A grant is held until the selected target acks, one access at a time.
 Cores must hold req, addr, wen and wdata stable until their ack pulse.
 One idle edge separates consecutive accesses.
*/
`timescale 1ns/10ps
`include "mp64_defines.svh"

module core_bus_arbiter (
    input  logic                                       sys_clk,
    input  logic                                       sys_rst_n,

    // Core side, one slice per core
    input  logic [`MP64_NUM_CORES-1:0]                 core_req,
    input  mp64_pkg::addr_t [`MP64_NUM_CORES-1:0]      core_addr,
    input  logic [`MP64_NUM_CORES-1:0]                 core_wen,
    input  mp64_pkg::word_t [`MP64_NUM_CORES-1:0]      core_wdata,
    output mp64_pkg::word_t [`MP64_NUM_CORES-1:0]      core_rdata,
    output logic [`MP64_NUM_CORES-1:0]                 core_ack,

    // Target side, shared by both regions
    output logic                                       mem_req,
    output logic                                       reg_req,
    output mp64_pkg::addr_t                            addr,
    output logic                                       wen,
    output mp64_pkg::word_t                            wdata,
    output mp64_pkg::core_id_t                         requester_id,
    input  mp64_pkg::word_t                            mem_rdata,
    input  logic                                       mem_ack,
    input  mp64_pkg::word_t                            reg_rdata,
    input  logic                                       reg_ack
);

    import mp64_pkg::*;

    // ========================================
    // State
    // ========================================
    arb_state_e state_q;
    // Core currently owning the port
    core_id_t   grant_q;
    // Core served last, lowest priority next round
    core_id_t   last_grant_q;

    // Round-robin search result
    logic       found;
    core_id_t   next_grant;
    core_id_t   cand;

    // Region of the granted access
    logic       reg_region;
    logic       busy;
    logic       sel_ack;
    word_t      sel_rdata;
    logic [`MP64_NUM_CORES-1:0] winner;

    // ========================================
    // Round-robin search
    // ========================================
    // Scan upward from last_grant + 1 and wrap, last_grant itself comes last
    always_comb begin
        found      = 1'b0;
        next_grant = last_grant_q;
        cand       = last_grant_q;
        for (int unsigned step = 1; step <= `MP64_NUM_CORES; step++) begin
            cand = core_id_t'((last_grant_q + step) % `MP64_NUM_CORES);
            if (!found && core_req[cand]) begin
                found      = 1'b1;
                next_grant = cand;
            end
        end
    end

    // ========================================
    // Grant FSM
    // ========================================
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state_q      <= ARB_IDLE;
            grant_q      <= '0;
            last_grant_q <= '0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    // Grant registers here, target sees req next cycle
                    if (found) begin
                        grant_q <= next_grant;
                        state_q <= ARB_BUSY;
                    end
                end
                ARB_BUSY: begin
                    // Target ack closes the access
                    if (sel_ack) begin
                        state_q      <= ARB_IDLE;
                        last_grant_q <= grant_q;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    // ========================================
    // Request steering
    // ========================================
    assign busy         = (state_q == ARB_BUSY);
    // Winner's signals go to both targets, only one sees req
    assign addr         = core_addr[grant_q];
    assign wen          = core_wen[grant_q];
    assign wdata        = core_wdata[grant_q];
    assign requester_id = grant_q;

    // MSB of the word address picks the region
    assign reg_region   = addr[`MP64_ADDR_BITS-1];
    assign mem_req      = busy && !reg_region;
    assign reg_req      = busy && reg_region;

    // ========================================
    // Response return
    // ========================================
    // Only the addressed target may close the access
    assign sel_ack      = busy && (reg_region ? reg_ack : mem_ack);
    assign sel_rdata    = reg_region ? reg_rdata : mem_rdata;

    // Data and ack go to the granted core, others see zero
    always_comb begin
        for (int i = 0; i < `MP64_NUM_CORES; i++) begin
            winner[i]     = busy && (grant_q == core_id_t'(i));
            core_ack[i]   = winner[i] && sel_ack;
            core_rdata[i] = winner[i] ? sel_rdata : '0;
        end
    end

endmodule

// File: design/shared_ram.sv
/*
 Shared word RAM, 1024 x 64, indexed by the low RAM address bits.
 Contents are not cleared by reset and read as X until written.
 Ack comes one cycle after req is seen, a write leaves rdata as it was.
*/
`timescale 1ns/10ps
`include "mp64_defines.svh"

module shared_ram (
    input  logic               sys_clk,
    input  logic               sys_rst_n,
    input  logic               req,
    input  mp64_pkg::addr_t    addr,
    input  logic               wen,
    input  mp64_pkg::word_t    wdata,
    output mp64_pkg::word_t    rdata,
    output logic               ack
);

    import mp64_pkg::*;

    localparam int unsigned RAM_WORDS = 1 << `MP64_RAM_ADDR_BITS;

    // Storage
    word_t                          mem [RAM_WORDS];
    logic [`MP64_RAM_ADDR_BITS-1:0] idx;
    // First cycle of a held request
    logic                           access;
    logic                           ack_q;
    word_t                          rdata_q;

    // Region bit already stripped by the arbiter decode
    assign idx    = addr[`MP64_RAM_ADDR_BITS-1:0];
    assign access = req && !ack_q;

    // Ack pulse, never twice for one held req
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // Array write and registered read
    always_ff @(posedge sys_clk) begin
        if (access) begin
            if (wen) begin
                mem[idx] <= wdata;
            end else begin
                rdata_q <= mem[idx];
            end
        end
    end

    assign rdata = rdata_q;
    assign ack   = ack_q;

endmodule

// File: design/lock_regs.sv
/*
 System information registers and owner-tracked hardware spinlocks.
 Register writes ignore wdata, a lock write only releases when sent by its owner.
 Lock read returns 0 when acquired, 1 when already held.
 Ack comes one cycle after req is seen.
*/
`timescale 1ns/10ps
`include "mp64_defines.svh"

module lock_regs (
    input  logic                  sys_clk,
    input  logic                  sys_rst_n,
    input  logic                  req,
    input  mp64_pkg::addr_t       addr,
    input  logic                  wen,
    input  mp64_pkg::word_t       wdata,
    input  mp64_pkg::core_id_t    requester_id,
    output mp64_pkg::word_t       rdata,
    output logic                  ack
);

    import mp64_pkg::*;

    localparam int unsigned LOCK_IDX_BITS = $clog2(`MP64_NUM_LOCKS);
    // 1024 words of 8 bytes
    localparam word_t RAM_SIZE_BYTES =
        word_t'((1 << `MP64_RAM_ADDR_BITS) * (`MP64_DATA_BITS / 8));

    logic [`MP64_ADDR_BITS-2:0]      offset;
    reg_sel_e                        sel;
    logic [LOCK_IDX_BITS-1:0]        lock_idx;
    logic                            access;
    logic                            acquire;
    logic                            release_lock;
    logic                            ack_q;
    word_t                           rdata_q;
    word_t                           read_value;
    logic [`MP64_NUM_LOCKS-1:0]      lock_held_q;
    core_id_t                        lock_owner_q [`MP64_NUM_LOCKS];

    // ========================================
    // Address decode
    // ========================================
    function automatic reg_sel_e decode_sel(input logic [`MP64_ADDR_BITS-2:0] off);
        reg_sel_e s;
        if (off == 0) begin
            s = REG_ID;
        end else if (off == 1) begin
            s = REG_RAM_SIZE;
        end else if (off == 2) begin
            s = REG_CORE_COUNT;
        end else if (off >= `MP64_LOCK_BASE && off < `MP64_LOCK_BASE + `MP64_NUM_LOCKS) begin
            s = REG_LOCK;
        end else begin
            s = REG_NONE;
        end
        return s;
    endfunction

    assign offset   = addr[`MP64_ADDR_BITS-2:0];
    assign sel      = decode_sel(offset);
    // Only meaningful when sel is REG_LOCK
    assign lock_idx = LOCK_IDX_BITS'(offset - `MP64_LOCK_BASE);
    assign access   = req && !ack_q;

    // ========================================
    // Spinlock control
    // ========================================
    // Test-and-set on read
    assign acquire      = access && (sel == REG_LOCK) && !wen && !lock_held_q[lock_idx];
    // Release only by the current owner, data ignored
    assign release_lock = access && (sel == REG_LOCK) && wen && lock_held_q[lock_idx]
                          && (lock_owner_q[lock_idx] == requester_id);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            ack_q       <= 1'b0;
            lock_held_q <= '0;
        end else begin
            ack_q <= access;
            if (acquire) begin
                lock_held_q[lock_idx] <= 1'b1;
            end else if (release_lock) begin
                lock_held_q[lock_idx] <= 1'b0;
            end
        end
    end

    // ========================================
    // Read data
    // ========================================
    always_comb begin
        case (sel)
            REG_ID:         read_value = `MP64_SYSINFO_ID;
            REG_RAM_SIZE:   read_value = RAM_SIZE_BYTES;
            REG_CORE_COUNT: read_value = word_t'(`MP64_NUM_CORES);
            // Old held bit, so the winner of a free lock sees 0
            REG_LOCK:       read_value = word_t'(lock_held_q[lock_idx]);
            default:        read_value = '0;
        endcase
    end

    // Owner tag and read register, valid only alongside held bit and ack
    always_ff @(posedge sys_clk) begin
        if (acquire) begin
            lock_owner_q[lock_idx] <= requester_id;
        end
        if (access && !wen) begin
            rdata_q <= read_value;
        end
    end

    assign rdata = rdata_q;
    assign ack   = ack_q;

endmodule

// File: design/mp64_shared_port.sv
/*
 Shared memory port top, cores -> arbiter -> RAM or register unit.
 Address MSB 0 goes to RAM, 1 to the system registers and spinlocks.
 Lone request into an idle port is acked two edges after it is first sampled.
*/
`timescale 1ns/10ps
`include "mp64_defines.svh"

module mp64_shared_port (
    input  logic                                       sys_clk,
    input  logic                                       sys_rst_n,

    // Per-core level request, held until ack
    input  logic [`MP64_NUM_CORES-1:0]                 core_req,
    input  mp64_pkg::addr_t [`MP64_NUM_CORES-1:0]      core_addr,
    input  logic [`MP64_NUM_CORES-1:0]                 core_wen,
    input  mp64_pkg::word_t [`MP64_NUM_CORES-1:0]      core_wdata,
    output mp64_pkg::word_t [`MP64_NUM_CORES-1:0]      core_rdata,
    output logic [`MP64_NUM_CORES-1:0]                 core_ack
);

    import mp64_pkg::*;

    // ========================================
    // Target bus
    // ========================================
    logic      mem_req;
    logic      reg_req;
    addr_t     addr;
    logic      wen;
    word_t     wdata;
    // Granted core, keys the spinlock owner
    core_id_t  requester_id;

    // Responses
    word_t     mem_rdata;
    logic      mem_ack;
    word_t     reg_rdata;
    logic      reg_ack;

    // Round-robin arbiter, producer of granted accesses
    core_bus_arbiter u_arbiter (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .core_req     (core_req),
        .core_addr    (core_addr),
        .core_wen     (core_wen),
        .core_wdata   (core_wdata),
        .core_rdata   (core_rdata),
        .core_ack     (core_ack),
        .mem_req      (mem_req),
        .reg_req      (reg_req),
        .addr         (addr),
        .wen          (wen),
        .wdata        (wdata),
        .requester_id (requester_id),
        .mem_rdata    (mem_rdata),
        .mem_ack      (mem_ack),
        .reg_rdata    (reg_rdata),
        .reg_ack      (reg_ack)
    );

    // Shared RAM
    shared_ram u_ram (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .req       (mem_req),
        .addr      (addr),
        .wen       (wen),
        .wdata     (wdata),
        .rdata     (mem_rdata),
        .ack       (mem_ack)
    );

    // System info and spinlocks
    lock_regs u_regs (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .req          (reg_req),
        .addr         (addr),
        .wen          (wen),
        .wdata        (wdata),
        .requester_id (requester_id),
        .rdata        (reg_rdata),
        .ack          (reg_ack)
    );

endmodule

// File: testbench/tb_mp64_shared_port.sv
/*
 Four random requesters against a reference model of RAM, registers and locks.
 RAM traffic stays in a 16 word window, words not yet written are not checked.
 A directed tail sends one lone request per core to measure idle latency.
 The fork in the main block assumes MP64_NUM_CORES is 4.
*/
`timescale 1ns/10ps
`include "mp64_defines.svh"

module tb_mp64_shared_port;

    import mp64_pkg::*;

    localparam int NUM_CORES      = `MP64_NUM_CORES;
    localparam int ACCESSES       = 500;
    localparam int OFF_BITS       = `MP64_ADDR_BITS - 1;
    localparam int RAM_WORDS      = 1 << `MP64_RAM_ADDR_BITS;
    // 8 cycles worst case per access, all cores serialized, plus margin
    localparam int TIMEOUT_CYCLES = NUM_CORES * ACCESSES * 8 + 4000;
    localparam int UNMAPPED [4]   = '{3, 'h0F, 'h18, 'h3FF};

    logic                      sys_clk;
    logic                      sys_rst_n;
    logic [NUM_CORES-1:0]      core_req;
    addr_t [NUM_CORES-1:0]     core_addr;
    logic [NUM_CORES-1:0]      core_wen;
    word_t [NUM_CORES-1:0]     core_wdata;
    word_t [NUM_CORES-1:0]     core_rdata;
    logic [NUM_CORES-1:0]      core_ack;

    // Reference model
    word_t                     ram_model [RAM_WORDS];
    logic [RAM_WORDS-1:0]      ram_written = '0;
    logic [`MP64_NUM_LOCKS-1:0] lock_held = '0;
    core_id_t                  lock_owner [`MP64_NUM_LOCKS];

    // Request tracking, sampled at the falling edge
    logic [NUM_CORES-1:0]      prev_req = '0;
    logic [NUM_CORES-1:0]      pending = '0;
    logic [NUM_CORES-1:0]      lone = '0;
    int                        req_cycle [NUM_CORES] = '{default: 0};
    int                        others_acks [NUM_CORES] = '{default: 0};
    int                        ack_total [NUM_CORES] = '{default: 0};
    int                        ack_index = 0;
    int                        lone_checks = 0;
    int                        cycle_count = 0;
    int                        checks = 0;
    int                        value_errors = 0;
    int                        protocol_errors = 0;

    mp64_shared_port i_dut (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .core_req   (core_req),
        .core_addr  (core_addr),
        .core_wen   (core_wen),
        .core_wdata (core_wdata),
        .core_rdata (core_rdata),
        .core_ack   (core_ack)
    );

    initial begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    // ========================================
    // Checking helpers
    // ========================================
    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        protocol_errors++;
        $display("Protocol failure at cycle %0d: %s", cycle_count, what);
    endtask

    task automatic print_summary();
        $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
                 checks, value_errors, protocol_errors);
    endtask

    // Register offset classes of the system register region
    function automatic reg_sel_e classify_offset(input logic [OFF_BITS-1:0] off);
        int o;
        o = int'(off);
        if (o >= `MP64_LOCK_BASE && o < `MP64_LOCK_BASE + `MP64_NUM_LOCKS) begin
            return REG_LOCK;
        end
        case (o)
            0: return REG_ID;
            1: return REG_RAM_SIZE;
            2: return REG_CORE_COUNT;
            default: return REG_NONE;
        endcase
    endfunction

    function automatic addr_t reg_addr(input int off);
        return addr_t'((1 << OFF_BITS) | off);
    endfunction

    // ========================================
    // Reference model, applied in ack order
    // ========================================
    task automatic apply_access(input int k, input addr_t a, input logic w,
                                input word_t d, input word_t rd);
        int                  idx;
        int                  li;
        logic [OFF_BITS-1:0] off;
        idx = int'(a[`MP64_RAM_ADDR_BITS-1:0]);
        off = a[OFF_BITS-1:0];
        li  = int'(off) - `MP64_LOCK_BASE;
        if (!a[`MP64_ADDR_BITS-1]) begin
            if (w) begin
                ram_model[idx]   = d;
                ram_written[idx] = 1'b1;
            end else if (ram_written[idx]) begin
                check_value("ram_read", ram_model[idx], rd);
            end
        end else begin
            // Writes to the info registers change nothing in the model
            case (classify_offset(off))
                REG_ID:         if (!w) check_value("sysinfo_id", `MP64_SYSINFO_ID, rd);
                REG_RAM_SIZE:   if (!w) check_value("ram_size", 64'd8192, rd);
                REG_CORE_COUNT: if (!w) check_value("core_count", word_t'(NUM_CORES), rd);
                REG_LOCK: begin
                    if (!w) begin
                        check_value(lock_held[li] ? "lock_contend" : "lock_acquire",
                                    word_t'(lock_held[li]), rd);
                        if (!lock_held[li]) begin
                            lock_held[li]  = 1'b1;
                            lock_owner[li] = core_id_t'(k);
                        end
                    end else if (lock_held[li] && lock_owner[li] == core_id_t'(k)) begin
                        // Owner release, other writers are ignored
                        lock_held[li] = 1'b0;
                    end
                end
                default:        if (!w) check_value("unmapped_read", '0, rd);
            endcase
        end
    endtask

    task automatic handle_ack(input int k);
        if (!pending[k] || !core_req[k]) begin
            report_failure($sformatf("ack to core %0d without a pending request", k));
        end else begin
            pending[k] = 1'b0;
            ack_total[k]++;
            // All cores start together and last_grant resets to 0
            if (ack_index < NUM_CORES) begin
                check_value("first_ack_order", word_t'((ack_index + 1) % NUM_CORES),
                            word_t'(k));
            end
            ack_index++;
            // Edge sampling the request to edge sampling the ack
            if (lone[k]) begin
                lone_checks++;
                check_value("lone_latency", 64'd2, word_t'(cycle_count - req_cycle[k]));
            end
            for (int c = 0; c < NUM_CORES; c++) begin
                if (c != k && pending[c]) begin
                    others_acks[c]++;
                    if (others_acks[c] > NUM_CORES - 1) begin
                        report_failure($sformatf("core %0d passed over %0d times",
                                                 c, others_acks[c]));
                    end
                end
            end
            apply_access(k, core_addr[k], core_wen[k], core_wdata[k], core_rdata[k]);
        end
    endtask

    // ========================================
    // Requesters
    // ========================================
    // One access, held from a rising edge until its ack pulse
    task automatic issue_access(input int c, input addr_t a, input logic w, input word_t d);
        @(posedge sys_clk);
        core_req[c]   <= 1'b1;
        core_addr[c]  <= a;
        core_wen[c]   <= w;
        core_wdata[c] <= d;
        do begin
            @(negedge sys_clk);
        end while (!core_ack[c]);
        @(posedge sys_clk);
        core_req[c] <= 1'b0;
    endtask

    task automatic run_core(input int c);
        int    kind;
        int    idle;
        addr_t a;
        logic  w;
        word_t d;
        for (int n = 0; n < ACCESSES; n++) begin
            kind = int'($urandom_range(99, 0));
            // First access without idle time, so all cores contend at once
            idle = (n == 0) ? 0 : int'($urandom_range(3, 0));
            if (kind < 50) begin
                a = addr_t'($urandom_range(15, 0));
            end else if (kind < 65) begin
                a = reg_addr(int'($urandom_range(2, 0)));
            end else if (kind < 70) begin
                a = reg_addr(UNMAPPED[$urandom_range(3, 0)]);
            end else begin
                a = reg_addr(`MP64_LOCK_BASE + int'($urandom_range(`MP64_NUM_LOCKS - 1, 0)));
            end
            w = ($urandom_range(1, 0) == 1);
            d = {$urandom, $urandom};
            repeat (idle) @(posedge sys_clk);
            issue_access(c, a, w, d);
        end
    endtask

    // ========================================
    // Monitor and watchdog
    // ========================================
    always @(negedge sys_clk) begin
        if (!sys_rst_n) begin
            if (core_ack != '0) begin
                report_failure("core_ack high during reset");
            end
        end else begin
            if ($countones(core_ack) > 1) begin
                report_failure("more than one core acked in the same cycle");
            end
            for (int c = 0; c < NUM_CORES; c++) begin
                if (core_req[c] && !prev_req[c]) begin
                    pending[c]     = 1'b1;
                    lone[c]        = ($countones(core_req) == 1);
                    req_cycle[c]   = cycle_count;
                    others_acks[c] = 0;
                end
                if (core_ack[c]) begin
                    handle_ack(c);
                end
            end
        end
        prev_req = core_req;
    end

    always @(posedge sys_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: accesses still open after %0d cycles", TIMEOUT_CYCLES);
            print_summary();
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        sys_rst_n  <= 1'b0;
        core_req   <= '0;
        core_addr  <= '0;
        core_wen   <= '0;
        core_wdata <= '0;
        void'($urandom(20613));
        repeat (5) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
        fork
            run_core(0);
            run_core(1);
            run_core(2);
            run_core(3);
        join
        // Lone ID reads into an idle port, one per core
        for (int c = 0; c < NUM_CORES; c++) begin
            repeat (2) @(posedge sys_clk);
            issue_access(c, reg_addr(0), 1'b0, '0);
        end
        // Quiet tail so a late or repeated ack is still seen
        repeat (10) @(posedge sys_clk);
        for (int c = 0; c < NUM_CORES; c++) begin
            check_value($sformatf("ack_count_core%0d", c), word_t'(ACCESSES + 1),
                        word_t'(ack_total[c]));
        end
        if (lone_checks < NUM_CORES) begin
            report_failure("lone request latency measured fewer times than requests sent");
        end
        print_summary();
        if (value_errors + protocol_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
design/mp64_pkg.sv
design/core_bus_arbiter.sv
design/shared_ram.sv
design/lock_regs.sv
design/mp64_shared_port.sv
testbench/tb_mp64_shared_port.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the shared port testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing -j 0 \
    --top-module tb_mp64_shared_port \
    -Mdir "$BUILD" \
    -o tb_mp64_shared_port \
    -f verilog.f

"./$BUILD/tb_mp64_shared_port" | tee "$LOG"

# Verdict comes from the log
if grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $LOG"
exit 1
